// ==== Makefile ====
TOP := rv_core_pipe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f rv_core_pipe.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q 'TESTS PASSED'

clean:
	rm -rf obj_dir

// ==== bench/rv_test_table.svh ====
// pipeline test table
`ifndef RV_TEST_TABLE_SVH
`define RV_TEST_TABLE_SVH

// columns: instr, pc, wen, rd, data, redirect, target, exception
typedef struct packed {
  logic      valid;
  instr_t    instr;
  word_t     pc;
  logic      wen;
  reg_addr_t rd;
  word_t     data;
  logic      redir;
  word_t     target;
  exc_t      exc;
} test_entry_t;

test_entry_t test_table[$];

task automatic add_entry(input instr_t instr, input word_t pc, input logic wen,
                         input reg_addr_t rd, input word_t data, input logic redir,
                         input word_t target, input exc_t exc);
  test_entry_t e;
  e.valid  = 1'b1;
  e.instr  = instr;
  e.pc     = pc;
  e.wen    = wen;
  e.rd     = rd;
  e.data   = data;
  e.redir  = redir;
  e.target = target;
  e.exc    = exc;
  test_table.push_back(e);
endtask

// a cycle with no instruction strobe
task automatic add_bubble();
  test_entry_t e;
  e = '0;
  test_table.push_back(e);
endtask

task automatic build_table();
  // addi, add, sub, shifts, slt/sltu and logic ops, chained at distance 1 to 3
  add_entry(32'h00500093, 32'h100, 1'b1, 5'd1, 32'h00000005, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'hFFD00113, 32'h104, 1'b1, 5'd2, 32'hFFFFFFFD, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h002081B3, 32'h108, 1'b1, 5'd3, 32'h00000002, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h40208233, 32'h10C, 1'b1, 5'd4, 32'h00000008, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h00321293, 32'h110, 1'b1, 5'd5, 32'h00000040, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h40115313, 32'h114, 1'b1, 5'd6, 32'hFFFFFFFE, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h00415393, 32'h118, 1'b1, 5'd7, 32'h0FFFFFFF, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h00112433, 32'h11C, 1'b1, 5'd8, 32'h00000001, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h001134B3, 32'h120, 1'b1, 5'd9, 32'h00000000, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h0FF0C513, 32'h124, 1'b1, 5'd10, 32'h000000FA, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h0042E5B3, 32'h128, 1'b1, 5'd11, 32'h00000048, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h00B57633, 32'h12C, 1'b1, 5'd12, 32'h00000048, 1'b0, 32'h0, EXC_NONE);
  // write to x0, then read x0 right behind it
  add_entry(32'h00108013, 32'h130, 1'b1, 5'd0, 32'h00000006, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h000006B3, 32'h134, 1'b1, 5'd13, 32'h00000000, 1'b0, 32'h0, EXC_NONE);
  add_bubble();
  add_bubble();
  // lui, auipc, jal, then jalr on the fresh link value
  add_entry(32'h12345737, 32'h138, 1'b1, 5'd14, 32'h12345000, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h00001797, 32'h13C, 1'b1, 5'd15, 32'h0000113C, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h010000EF, 32'h140, 1'b1, 5'd1, 32'h00000144, 1'b1, 32'h150, EXC_NONE);
  add_entry(32'h003082E7, 32'h144, 1'b1, 5'd5, 32'h00000148, 1'b1, 32'h146, EXC_NONE);
  // beq taken, bne not, blt taken, bltu not, bgeu and bge taken
  add_entry(32'h00D48463, 32'h148, 1'b0, 5'd0, 32'h0, 1'b1, 32'h150, EXC_NONE);
  add_entry(32'h00D49463, 32'h14C, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'hFE1148E3, 32'h150, 1'b0, 5'd0, 32'h0, 1'b1, 32'h140, EXC_NONE);
  add_entry(32'h00116463, 32'h154, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, EXC_NONE);
  add_entry(32'h00117663, 32'h158, 1'b0, 5'd0, 32'h0, 1'b1, 32'h164, EXC_NONE);
  add_entry(32'hFE20DEE3, 32'h15C, 1'b0, 5'd0, 32'h0, 1'b1, 32'h158, EXC_NONE);
  add_bubble();
  // bad opcode, mul as bad funct7, ecall, ebreak, jal x1 to itself
  add_entry(32'h0000007F, 32'h160, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, EXC_ILLEGAL);
  add_entry(32'h022081B3, 32'h164, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, EXC_ILLEGAL);
  add_entry(32'h00000073, 32'h168, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, EXC_ECALL);
  add_entry(32'h00100073, 32'h16C, 1'b0, 5'd0, 32'h0, 1'b0, 32'h0, EXC_EBREAK);
  add_entry(32'h000000EF, 32'h170, 1'b0, 5'd0, 32'h0, 1'b1, 32'h170, EXC_HALT);
  // x1 and x3 must be untouched by the suppressed writes
  add_entry(32'h00308833, 32'h174, 1'b1, 5'd16, 32'h00000146, 1'b0, 32'h0, EXC_NONE);
endtask

`endif

// ==== bench/rv_core_pipe_tb.sv ====
// rv32i pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module rv_core_pipe_tb;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  // cycles from the driving edge to the result strobe
  localparam int PIPE_DEPTH = 3;

  logic      clk_i;
  logic      reset_i;
  logic      instr_valid_i;
  instr_t    instr_i;
  word_t     pc_i;
  logic      wb_valid_o;
  logic      wb_we_o;
  reg_addr_t wb_rd_o;
  word_t     wb_data_o;
  logic      redirect_valid_o;
  word_t     redirect_pc_o;
  exc_t      exc_o;

  // table index and issue cycle of every instruction in flight
  int   pending_idx[$];
  int   pending_cyc[$];
  int   cycle_cnt;
  int   timeout_limit;
  logic checking;

  `include "rv_test_table.svh"

  rv_core_pipe #(
    .HALT_ON_SELF_JUMP (1'b1)
  ) dut0 (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .pc_i             (pc_i),
    .wb_valid_o       (wb_valid_o),
    .wb_we_o          (wb_we_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .exc_o            (exc_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error at %0d ns: %s is x%0d, expected x%0d", $time, what, got,
                               exp));
    end
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_exc(input string what, input exc_t got, input exc_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // rd and data only matter on a write and the target only on a redirect
  task automatic compare_result(input int idx);
    test_entry_t e;
    e = test_table[idx];
    check_flag($sformatf("entry %0d write enable", idx), wb_we_o, e.wen);
    if (e.wen) begin
      check_reg($sformatf("entry %0d rd", idx), wb_rd_o, e.rd);
      check_word($sformatf("entry %0d write data", idx), wb_data_o, e.data);
    end
    check_flag($sformatf("entry %0d redirect", idx), redirect_valid_o, e.redir);
    if (e.redir) begin
      check_word($sformatf("entry %0d redirect target", idx), redirect_pc_o, e.target);
    end
    check_exc($sformatf("entry %0d exception", idx), exc_o, e.exc);
  endtask

  // outputs are sampled half a cycle after the edge that updates them
  always @(negedge clk_i) begin
    logic due;
    due = 1'b0;
    if (pending_cyc.size() != 0 && cycle_cnt - pending_cyc[0] == PIPE_DEPTH) begin
      due = 1'b1;
    end
    if (checking) begin
      check_flag("result strobe", wb_valid_o, due);
      if (due) begin
        compare_result(pending_idx[0]);
        void'(pending_idx.pop_front());
        void'(pending_cyc.pop_front());
      end
    end
    if (cycle_cnt > timeout_limit) begin
      report_failure($sformatf("timeout: %0d results still missing after %0d cycles",
                               pending_idx.size(), cycle_cnt));
    end
    cycle_cnt = cycle_cnt + 1;
  end

  initial begin
    test_entry_t e;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    cycle_cnt     = 0;
    checking      = 1'b0;
    build_table();
    timeout_limit = test_table.size() + 20;

    repeat (3) @(posedge clk_i);
    reset_i  <= 1'b0;
    checking <= 1'b1;
    // strobe has to stay low while idle
    repeat (3) @(posedge clk_i);

    for (int i = 0; i < test_table.size(); i++) begin
      e = test_table[i];
      instr_valid_i <= e.valid;
      instr_i       <= e.instr;
      pc_i          <= e.pc;
      if (e.valid) begin
        pending_idx.push_back(i);
        pending_cyc.push_back(cycle_cnt);
      end
      @(posedge clk_i);
    end
    instr_valid_i <= 1'b0;

    while (pending_idx.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_core_pipe.f ====
+incdir+bench
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_stage_if.sv
verilog/rv_decode.sv
verilog/rv_operand_read.sv
verilog/rv_execute.sv
verilog/rv_core_pipe.sv
bench/rv_core_pipe_tb.sv

// ==== verilog/rv_core_pipe.sv ====
// three stage rv32i execution pipeline
`timescale 1ns/1ps
`default_nettype none

module rv_core_pipe #(
  parameter bit HALT_ON_SELF_JUMP = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  rv_isa_pkg::instr_t    instr_i,
  input  rv_isa_pkg::word_t     pc_i,
  output logic                  wb_valid_o,
  output logic                  wb_we_o,
  output rv_isa_pkg::reg_addr_t wb_rd_o,
  output rv_isa_pkg::word_t     wb_data_o,
  output logic                  redirect_valid_o,
  output rv_isa_pkg::word_t     redirect_pc_o,
  output rv_ctrl_pkg::exc_t     exc_o
);
  import rv_isa_pkg::*;

  // execute to operand read forwarding
  logic      fwd_valid;
  reg_addr_t fwd_rd;
  word_t     fwd_data;

  dec_bus_if dec_bus ();
  exe_bus_if exe_bus ();

  rv_decode #(
    .HALT_ON_SELF_JUMP (HALT_ON_SELF_JUMP)
  ) u_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .dec           (dec_bus)
  );

  // write-back comes from the result register outputs
  rv_operand_read u_operand_read (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dec         (dec_bus),
    .exe         (exe_bus),
    .wb_we_i     (wb_we_o),
    .wb_rd_i     (wb_rd_o),
    .wb_data_i   (wb_data_o),
    .fwd_valid_i (fwd_valid),
    .fwd_rd_i    (fwd_rd),
    .fwd_data_i  (fwd_data)
  );

  rv_execute u_execute (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .exe              (exe_bus),
    .fwd_valid_o      (fwd_valid),
    .fwd_rd_o         (fwd_rd),
    .fwd_data_o       (fwd_data),
    .wb_valid_o       (wb_valid_o),
    .wb_we_o          (wb_we_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .exc_o            (exc_o)
  );

endmodule

`default_nettype wire

// ==== verilog/rv_ctrl_pkg.sv ====
// pipeline control definitions
`default_nettype none

package rv_ctrl_pkg;

  typedef logic [3:0] alu_op_t;
  typedef logic [1:0] wsrc_t;
  typedef logic [1:0] src_sel_t;
  typedef logic [2:0] exc_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SRL  = 4'd3;
  localparam alu_op_t ALU_SRA  = 4'd4;
  localparam alu_op_t ALU_AND  = 4'd5;
  localparam alu_op_t ALU_OR   = 4'd6;
  localparam alu_op_t ALU_XOR  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;

  // write-back source
  localparam wsrc_t WSRC_ALU  = 2'd0;
  localparam wsrc_t WSRC_LINK = 2'd1;
  localparam wsrc_t WSRC_UIMM = 2'd2;

  // operand a picks reg or pc, operand b picks reg or imm
  localparam src_sel_t SRC_A_REG = 2'd0;
  localparam src_sel_t SRC_A_PC  = 2'd1;
  localparam src_sel_t SRC_B_REG = 2'd0;
  localparam src_sel_t SRC_B_IMM = 2'd1;

  localparam exc_t EXC_NONE    = 3'd0;
  localparam exc_t EXC_ILLEGAL = 3'd1;
  localparam exc_t EXC_ECALL   = 3'd2;
  localparam exc_t EXC_EBREAK  = 3'd3;
  localparam exc_t EXC_HALT    = 3'd4;

endpackage

`default_nettype wire

// ==== verilog/rv_decode.sv ====
// rv32i decode stage
`timescale 1ns/1ps
`default_nettype none

module rv_decode #(
  parameter bit HALT_ON_SELF_JUMP = 1'b1
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               instr_valid_i,
  input  rv_isa_pkg::instr_t instr_i,
  input  rv_isa_pkg::word_t  pc_i,
  dec_bus_if.dec             dec
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  opcode_t  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  funct12_t funct12;
  word_t    imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic     alu_imm, alu_reg;
  logic     wen, illegal, is_ecall, is_ebreak, is_halt;
  src_sel_t src_a_sel, src_b_sel;
  wsrc_t    wsrc;
  alu_op_t  alu_op;
  exc_t     exc;

  // instruction fields
  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[14:12];
  assign funct7  = instr_i[31:25];
  assign funct12 = instr_i[31:20];

  // immediates, all sign extended except U
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    case (opcode)
      STORE:       imm = imm_s;
      BRANCH:      imm = imm_b;
      LUI, AUIPC:  imm = imm_u;
      JAL:         imm = imm_j;
      default:     imm = imm_i;
    endcase
  end

  // loads and stores write nothing here
  always_comb begin
    case (opcode)
      IMMED, REGREG, LUI, AUIPC, JAL, JALR: wen = 1'b1;
      default:                              wen = 1'b0;
    endcase
  end

  assign src_a_sel = (opcode == AUIPC) ? SRC_A_PC : SRC_A_REG;
  assign src_b_sel = (opcode == REGREG || opcode == BRANCH) ? SRC_B_REG : SRC_B_IMM;

  always_comb begin
    case (opcode)
      JAL, JALR: wsrc = WSRC_LINK;
      LUI:       wsrc = WSRC_UIMM;
      default:   wsrc = WSRC_ALU;
    endcase
  end

  // alu op from funct3, bit 30 picks sub and sra
  assign alu_imm = (opcode == IMMED);
  assign alu_reg = (opcode == REGREG);

  always_comb begin
    alu_op = ALU_ADD;
    if (alu_imm || alu_reg) begin
      case (funct3)
        F3_ADD:  alu_op = (alu_reg && instr_i[30]) ? ALU_SUB : ALU_ADD;
        F3_SLL:  alu_op = ALU_SLL;
        F3_SLT:  alu_op = ALU_SLT;
        F3_SLTU: alu_op = ALU_SLTU;
        F3_XOR:  alu_op = ALU_XOR;
        F3_SR:   alu_op = instr_i[30] ? ALU_SRA : ALU_SRL;
        F3_OR:   alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  assign is_ecall  = (opcode == SYSTEM) && (funct3 == F3_PRIV) && (funct12 == F12_ECALL);
  assign is_ebreak = (opcode == SYSTEM) && (funct3 == F3_PRIV) && (funct12 == F12_EBREAK);
  // jal to itself, used to end a program
  assign is_halt   = HALT_ON_SELF_JUMP && (opcode == JAL) && (imm_j == '0);

  always_comb begin
    case (opcode)
      REGREG:  illegal = !(funct7 == F7_BASE ||
                           (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)));
      // no csr support, only ecall and ebreak
      SYSTEM:  illegal = !(is_ecall || is_ebreak);
      LUI, AUIPC, JAL, JALR, BRANCH,
      LOAD, STORE, IMMED, MISCMEM: illegal = 1'b0;
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    if (illegal)        exc = EXC_ILLEGAL;
    else if (is_ecall)  exc = EXC_ECALL;
    else if (is_ebreak) exc = EXC_EBREAK;
    else if (is_halt)   exc = EXC_HALT;
    else                exc = EXC_NONE;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    dec.pc          <= pc_i;
    dec.rs1         <= instr_i[19:15];
    dec.rs2         <= instr_i[24:20];
    dec.rd          <= instr_i[11:7];
    dec.wen         <= wen && (exc == EXC_NONE);
    dec.imm         <= imm;
    dec.src_a_sel   <= src_a_sel;
    dec.src_b_sel   <= src_b_sel;
    dec.alu_op      <= alu_op;
    dec.wsrc        <= wsrc;
    dec.branch      <= (opcode == BRANCH);
    dec.branch_type <= funct3;
    dec.jump        <= (opcode == JAL) || (opcode == JALR);
    dec.jalr        <= (opcode == JALR);
    dec.exc         <= exc;
  end

  a_no_wen_on_exc: assert property (@(posedge clk_i) disable iff (reset_i)
    dec.valid |-> !(dec.wen && dec.exc != EXC_NONE));

endmodule

`default_nettype wire

// ==== verilog/rv_execute.sv ====
// alu, branch and result register
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  logic                  clk_i,
  input  logic                  reset_i,
  exe_bus_if.exe                exe,
  output logic                  fwd_valid_o,
  output rv_isa_pkg::reg_addr_t fwd_rd_o,
  output rv_isa_pkg::word_t     fwd_data_o,
  output logic                  wb_valid_o,
  output logic                  wb_we_o,
  output rv_isa_pkg::reg_addr_t wb_rd_o,
  output rv_isa_pkg::word_t     wb_data_o,
  output logic                  redirect_valid_o,
  output rv_isa_pkg::word_t     redirect_pc_o,
  output rv_ctrl_pkg::exc_t     exc_o
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  word_t      alu_res, wdata, target, jalr_sum;
  logic [4:0] shamt;
  logic       cond, taken;

  assign shamt = exe.op_b[4:0];

  always_comb begin
    case (exe.alu_op)
      ALU_SUB:  alu_res = exe.op_a - exe.op_b;
      ALU_SLL:  alu_res = exe.op_a << shamt;
      ALU_SRL:  alu_res = exe.op_a >> shamt;
      ALU_SRA:  alu_res = word_t'($signed(exe.op_a) >>> shamt);
      ALU_AND:  alu_res = exe.op_a & exe.op_b;
      ALU_OR:   alu_res = exe.op_a | exe.op_b;
      ALU_XOR:  alu_res = exe.op_a ^ exe.op_b;
      ALU_SLT:  alu_res = {31'b0, $signed(exe.op_a) < $signed(exe.op_b)};
      ALU_SLTU: alu_res = {31'b0, exe.op_a < exe.op_b};
      default:  alu_res = exe.op_a + exe.op_b;
    endcase
  end

  always_comb begin
    case (exe.wsrc)
      WSRC_LINK: wdata = exe.pc + 32'd4;
      WSRC_UIMM: wdata = exe.imm;
      default:   wdata = alu_res;
    endcase
  end

  // branch compare works on the raw register values
  always_comb begin
    case (exe.branch_type)
      F3_BEQ:  cond = (exe.rs1_val == exe.rs2_val);
      F3_BNE:  cond = (exe.rs1_val != exe.rs2_val);
      F3_BLT:  cond = ($signed(exe.rs1_val) < $signed(exe.rs2_val));
      F3_BGE:  cond = ($signed(exe.rs1_val) >= $signed(exe.rs2_val));
      F3_BLTU: cond = (exe.rs1_val < exe.rs2_val);
      F3_BGEU: cond = (exe.rs1_val >= exe.rs2_val);
      default: cond = 1'b0;
    endcase
  end

  assign taken    = exe.jump || (exe.branch && cond);
  assign jalr_sum = exe.rs1_val + exe.imm;
  assign target   = exe.jalr ? {jalr_sum[31:1], 1'b0} : exe.pc + exe.imm;

  // unregistered result for the instruction right behind
  assign fwd_valid_o = exe.valid && exe.wen;
  assign fwd_rd_o    = exe.rd;
  assign fwd_data_o  = wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_o       <= 1'b0;
      wb_we_o          <= 1'b0;
      redirect_valid_o <= 1'b0;
      exc_o            <= EXC_NONE;
    end else begin
      wb_valid_o       <= exe.valid;
      wb_we_o          <= exe.valid && exe.wen;
      redirect_valid_o <= exe.valid && taken;
      exc_o            <= exe.valid ? exe.exc : EXC_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o       <= exe.rd;
    wb_data_o     <= wdata;
    redirect_pc_o <= target;
  end

  a_redirect_has_result: assert property (@(posedge clk_i) disable iff (reset_i)
    redirect_valid_o |-> wb_valid_o);

endmodule

`default_nettype wire

// ==== verilog/rv_isa_pkg.sv ====
// rv32i instruction set definitions
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN      = 32;
  localparam int REG_AW    = 5;
  localparam int NUM_REGS  = 32;
  localparam int OPCODE_W  = 7;
  localparam int FUNCT3_W  = 3;
  localparam int FUNCT7_W  = 7;
  localparam int FUNCT12_W = 12;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [XLEN-1:0]      instr_t;
  typedef logic [REG_AW-1:0]    reg_addr_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [FUNCT3_W-1:0]  funct3_t;
  typedef logic [FUNCT7_W-1:0]  funct7_t;
  typedef logic [FUNCT12_W-1:0] funct12_t;

  // major opcodes
  localparam opcode_t LUI     = 7'b0110111;
  localparam opcode_t AUIPC   = 7'b0010111;
  localparam opcode_t JAL     = 7'b1101111;
  localparam opcode_t JALR    = 7'b1100111;
  localparam opcode_t BRANCH  = 7'b1100011;
  localparam opcode_t LOAD    = 7'b0000011;
  localparam opcode_t STORE   = 7'b0100011;
  localparam opcode_t IMMED   = 7'b0010011;
  localparam opcode_t REGREG  = 7'b0110011;
  localparam opcode_t MISCMEM = 7'b0001111;
  localparam opcode_t SYSTEM  = 7'b1110011;

  // alu minor codes, shared by IMMED and REGREG
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // system minor codes
  localparam funct3_t  F3_PRIV    = 3'b000;
  localparam funct12_t F12_ECALL  = 12'h000;
  localparam funct12_t F12_EBREAK = 12'h001;

  // funct7 values legal for REGREG
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

// ==== verilog/rv_operand_read.sv ====
// register file and operand read stage
`timescale 1ns/1ps
`default_nettype none

module rv_operand_read (
  input  logic                  clk_i,
  input  logic                  reset_i,
  dec_bus_if.opr                dec,
  exe_bus_if.opr                exe,
  input  logic                  wb_we_i,
  input  rv_isa_pkg::reg_addr_t wb_rd_i,
  input  rv_isa_pkg::word_t     wb_data_i,
  input  logic                  fwd_valid_i,
  input  rv_isa_pkg::reg_addr_t fwd_rd_i,
  input  rv_isa_pkg::word_t     fwd_data_i
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  word_t regs [NUM_REGS];
  word_t rs1_val, rs2_val;
  word_t op_a, op_b;

  // execute result first, then result register, then the file
  function automatic word_t read_operand(reg_addr_t addr);
    word_t val;
    if (addr == '0) begin
      val = '0;
    end else if (fwd_valid_i && fwd_rd_i == addr) begin
      val = fwd_data_i;
    end else if (wb_we_i && wb_rd_i == addr) begin
      val = wb_data_i;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  always_comb begin
    rs1_val = read_operand(dec.rs1);
    rs2_val = read_operand(dec.rs2);
  end

  assign op_a = (dec.src_a_sel == SRC_A_PC) ? dec.pc : rs1_val;
  assign op_b = (dec.src_b_sel == SRC_B_IMM) ? dec.imm : rs2_val;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe.valid <= 1'b0;
    end else begin
      exe.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    exe.pc          <= dec.pc;
    exe.rd          <= dec.rd;
    exe.wen         <= dec.wen;
    exe.imm         <= dec.imm;
    exe.op_a        <= op_a;
    exe.op_b        <= op_b;
    exe.rs1_val     <= rs1_val;
    exe.rs2_val     <= rs2_val;
    exe.alu_op      <= dec.alu_op;
    exe.wsrc        <= dec.wsrc;
    exe.branch      <= dec.branch;
    exe.branch_type <= dec.branch_type;
    exe.jump        <= dec.jump;
    exe.jalr        <= dec.jalr;
    exe.exc         <= dec.exc;
  end

  // x0 must survive any write-back
  a_x0_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    regs[0] == '0);

endmodule

`default_nettype wire

// ==== verilog/rv_stage_if.sv ====
// stage to stage buses
`timescale 1ns/1ps
`default_nettype none

// decode to operand read
interface dec_bus_if;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic      valid;
  word_t     pc;
  reg_addr_t rs1, rs2, rd;
  logic      wen;
  word_t     imm;
  src_sel_t  src_a_sel, src_b_sel;
  alu_op_t   alu_op;
  wsrc_t     wsrc;
  logic      branch, jump, jalr;
  funct3_t   branch_type;
  exc_t      exc;

  modport dec (output valid, pc, rs1, rs2, rd, wen, imm, src_a_sel, src_b_sel,
               alu_op, wsrc, branch, branch_type, jump, jalr, exc);
  modport opr (input valid, pc, rs1, rs2, rd, wen, imm, src_a_sel, src_b_sel,
               alu_op, wsrc, branch, branch_type, jump, jalr, exc);
endinterface

// operand read to execute, operands already resolved
interface exe_bus_if;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic      valid;
  word_t     pc;
  reg_addr_t rd;
  logic      wen;
  word_t     imm;
  word_t     op_a, op_b;
  word_t     rs1_val, rs2_val;
  alu_op_t   alu_op;
  wsrc_t     wsrc;
  logic      branch, jump, jalr;
  funct3_t   branch_type;
  exc_t      exc;

  modport opr (output valid, pc, rd, wen, imm, op_a, op_b, rs1_val, rs2_val,
               alu_op, wsrc, branch, branch_type, jump, jalr, exc);
  modport exe (input valid, pc, rd, wen, imm, op_a, op_b, rs1_val, rs2_val,
               alu_op, wsrc, branch, branch_type, jump, jalr, exc);
endinterface

`default_nettype wire
